// File: hdl/wb_consts.svh
/* shared sram subsystem constants
   bus widths, memory depth and master count */

`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// byte address width
`define WB_ADDR_W 16

// data word and byte lanes
`define WB_DATA_W 32
`define WB_SEL_W  4

// memory depth in words
`define SRAM_WORDS 256

// masters sharing the bus
`define WB_N_MASTERS 3

`endif

// File: hdl/wb_pkg.sv
/* wishbone package
   bus field types and the master index type */

`include "wb_consts.svh"

package wb_pkg;

   // byte address as seen on adr
   typedef logic [`WB_ADDR_W-1:0] wb_addr_t;

   // one data word, read or write
   typedef logic [`WB_DATA_W-1:0] wb_data_t;

   // one enable per byte lane
   typedef logic [`WB_SEL_W-1:0] wb_sel_t;

   // index of a master on the shared bus
   typedef logic [$clog2(`WB_N_MASTERS)-1:0] master_id_t;

endpackage

// File: hdl/wishbone_if.sv
/* wishbone classic bus bundle
   request and response signals with master and slave views */

`timescale 1ns/1ps

interface wishbone_if;

   // request, driven by the master
   wb_pkg::wb_addr_t adr;
   wb_pkg::wb_data_t dat_w;
   wb_pkg::wb_sel_t  sel;
   logic             we;
   logic             stb;
   logic             cyc;

   // response, driven by the slave
   wb_pkg::wb_data_t dat_r;
   logic             ack;

   modport master (
      output adr,
      output dat_w,
      output sel,
      output we,
      output stb,
      output cyc,
      input  ack,
      input  dat_r
   );

   modport slave (
      input  adr,
      input  dat_w,
      input  sel,
      input  we,
      input  stb,
      input  cyc,
      output ack,
      output dat_r
   );

endinterface

// File: hdl/wb_arbiter.sv
/* round robin bus arbiter
   grants one master per wishbone cycle and holds it while cyc stays high */

`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_arbiter (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`WB_N_MASTERS-1:0] cyc_req,
   output wb_pkg::master_id_t       grant,
   output logic                     grant_valid
);

   import wb_pkg::*;

   master_id_t next_id;
   logic       found;
   int         cand;

   // first requester in rotation after the last owner
   always_comb begin
      next_id = grant;
      found   = 1'b0;
      cand    = 0;
      for (int k = 1; k <= `WB_N_MASTERS; k++) begin
         cand = (int'(grant) + k) % `WB_N_MASTERS;
         if (!found && cyc_req[cand]) begin
            found   = 1'b1;
            next_id = master_id_t'(cand);
         end
      end
   end

   // grant doubles as the last-granted pointer once the owner leaves
   always_ff @(posedge clk) begin
      if (rst) begin
         grant       <= master_id_t'(`WB_N_MASTERS - 1);
         grant_valid <= 1'b0;
      end else if (grant_valid) begin
         // release on the edge that sees the owner's cyc low
         if (!cyc_req[grant]) begin
            grant_valid <= 1'b0;
         end
      end else if (found) begin
         grant       <= next_id;
         grant_valid <= 1'b1;
      end
   end

endmodule

// File: hdl/wb_mux3to1.sv
/* three to one wishbone mux
   routes the granted master to the slave and the response back to that master only */

`timescale 1ns/1ps

module wb_mux3to1 (
   input wb_pkg::master_id_t grant,
   input logic               grant_valid,
   wishbone_if.slave         wb_m0,
   wishbone_if.slave         wb_m1,
   wishbone_if.slave         wb_m2,
   wishbone_if.master        wb_s
);

   import wb_pkg::*;

   always_comb begin
      // idle bus toward the slave unless a grant says otherwise
      wb_s.adr   = wb_m0.adr;
      wb_s.dat_w = wb_m0.dat_w;
      wb_s.sel   = wb_m0.sel;
      wb_s.we    = wb_m0.we;
      wb_s.stb   = 1'b0;
      wb_s.cyc   = 1'b0;

      // losers see a quiet response
      wb_m0.ack   = 1'b0;
      wb_m0.dat_r = wb_data_t'(0);
      wb_m1.ack   = 1'b0;
      wb_m1.dat_r = wb_data_t'(0);
      wb_m2.ack   = 1'b0;
      wb_m2.dat_r = wb_data_t'(0);

      if (grant_valid) begin
         case (grant)
            master_id_t'(0): begin
               wb_s.stb    = wb_m0.stb;
               wb_s.cyc    = wb_m0.cyc;
               wb_m0.ack   = wb_s.ack;
               wb_m0.dat_r = wb_s.dat_r;
            end
            master_id_t'(1): begin
               wb_s.adr    = wb_m1.adr;
               wb_s.dat_w  = wb_m1.dat_w;
               wb_s.sel    = wb_m1.sel;
               wb_s.we     = wb_m1.we;
               wb_s.stb    = wb_m1.stb;
               wb_s.cyc    = wb_m1.cyc;
               wb_m1.ack   = wb_s.ack;
               wb_m1.dat_r = wb_s.dat_r;
            end
            master_id_t'(2): begin
               wb_s.adr    = wb_m2.adr;
               wb_s.dat_w  = wb_m2.dat_w;
               wb_s.sel    = wb_m2.sel;
               wb_s.we     = wb_m2.we;
               wb_s.stb    = wb_m2.stb;
               wb_s.cyc    = wb_m2.cyc;
               wb_m2.ack   = wb_s.ack;
               wb_m2.dat_r = wb_s.dat_r;
            end
            // unused index keeps the idle bus
            default: begin
               wb_s.stb = 1'b0;
               wb_s.cyc = 1'b0;
            end
         endcase
      end
   end

endmodule

// File: hdl/wb_sram.sv
/* wishbone sram slave
   byte lane writes, whole word reads, registered single cycle ack */

`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_sram (
   input logic       clk,
   input logic       rst,
   wishbone_if.slave wb
);

   import wb_pkg::*;

   localparam int WORD_AW = $clog2(`SRAM_WORDS);
   localparam int LANE_AW = $clog2(`WB_SEL_W);

   wb_data_t               mem [`SRAM_WORDS];
   logic [WORD_AW-1:0]     word;
   logic                   access;

   // byte address to word index
   assign word = wb.adr[WORD_AW+LANE_AW-1:LANE_AW];

   // new strobe only while no ack is out
   assign access = wb.cyc && wb.stb && !wb.ack;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb.ack <= 1'b0;
      end else begin
         wb.ack <= access;
      end
   end

   // storage and read data
   always_ff @(posedge clk) begin
      if (access) begin
         if (wb.we) begin
            for (int i = 0; i < `WB_SEL_W; i++) begin
               if (wb.sel[i]) begin
                  mem[word][i*8 +: 8] <= wb.dat_w[i*8 +: 8];
               end
            end
         end else begin
            wb.dat_r <= mem[word];
         end
      end
   end

endmodule

// File: hdl/wb_shared_sram.sv
/* shared sram top
   three wishbone masters reach one sram through arbiter and mux */

`timescale 1ns/1ps

module wb_shared_sram (
   input  logic               clk,
   input  logic               rst,

   // master 0
   input  wb_pkg::wb_addr_t   m0_adr,
   input  wb_pkg::wb_data_t   m0_dat_w,
   input  wb_pkg::wb_sel_t    m0_sel,
   input  logic               m0_we,
   input  logic               m0_stb,
   input  logic               m0_cyc,
   output logic               m0_ack,
   output wb_pkg::wb_data_t   m0_dat_r,

   // master 1
   input  wb_pkg::wb_addr_t   m1_adr,
   input  wb_pkg::wb_data_t   m1_dat_w,
   input  wb_pkg::wb_sel_t    m1_sel,
   input  logic               m1_we,
   input  logic               m1_stb,
   input  logic               m1_cyc,
   output logic               m1_ack,
   output wb_pkg::wb_data_t   m1_dat_r,

   // master 2
   input  wb_pkg::wb_addr_t   m2_adr,
   input  wb_pkg::wb_data_t   m2_dat_w,
   input  wb_pkg::wb_sel_t    m2_sel,
   input  logic               m2_we,
   input  logic               m2_stb,
   input  logic               m2_cyc,
   output logic               m2_ack,
   output wb_pkg::wb_data_t   m2_dat_r
);

   import wb_pkg::*;

   master_id_t grant;
   logic       grant_valid;

   wishbone_if wb_m0 ();
   wishbone_if wb_m1 ();
   wishbone_if wb_m2 ();
   wishbone_if wb_s ();

   assign wb_m0.adr   = m0_adr;
   assign wb_m0.dat_w = m0_dat_w;
   assign wb_m0.sel   = m0_sel;
   assign wb_m0.we    = m0_we;
   assign wb_m0.stb   = m0_stb;
   assign wb_m0.cyc   = m0_cyc;
   assign m0_ack      = wb_m0.ack;
   assign m0_dat_r    = wb_m0.dat_r;

   assign wb_m1.adr   = m1_adr;
   assign wb_m1.dat_w = m1_dat_w;
   assign wb_m1.sel   = m1_sel;
   assign wb_m1.we    = m1_we;
   assign wb_m1.stb   = m1_stb;
   assign wb_m1.cyc   = m1_cyc;
   assign m1_ack      = wb_m1.ack;
   assign m1_dat_r    = wb_m1.dat_r;

   assign wb_m2.adr   = m2_adr;
   assign wb_m2.dat_w = m2_dat_w;
   assign wb_m2.sel   = m2_sel;
   assign wb_m2.we    = m2_we;
   assign wb_m2.stb   = m2_stb;
   assign wb_m2.cyc   = m2_cyc;
   assign m2_ack      = wb_m2.ack;
   assign m2_dat_r    = wb_m2.dat_r;

   // ownership follows cyc of each master
   wb_arbiter i_wb_arbiter (
      .clk         (clk),
      .rst         (rst),
      .cyc_req     ({wb_m2.cyc, wb_m1.cyc, wb_m0.cyc}),
      .grant       (grant),
      .grant_valid (grant_valid)
   );

   wb_mux3to1 i_wb_mux3to1 (
      .grant       (grant),
      .grant_valid (grant_valid),
      .wb_m0       (wb_m0),
      .wb_m1       (wb_m1),
      .wb_m2       (wb_m2),
      .wb_s        (wb_s)
   );

   wb_sram i_wb_sram (
      .clk (clk),
      .rst (rst),
      .wb  (wb_s)
   );

endmodule

// File: testbench/tb_wb_shared_sram.sv
/* testbench for the shared sram subsystem
   directed tests for transfers, byte lanes, round robin, locked cycles and isolation */

`timescale 1ns/1ps

`include "wb_consts.svh"

module tb_wb_shared_sram;

   import wb_pkg::*;

   localparam int MAX_CYCLES = 2000;
   localparam int WORD_AW    = $clog2(`SRAM_WORDS);

   logic                   clk;
   logic                   rst;
   wb_addr_t               m_adr   [3];
   wb_data_t               m_dat_w [3];
   wb_sel_t                m_sel   [3];
   logic                   m_we    [3];
   logic                   m_stb   [3];
   logic                   m_cyc   [3];
   wire  [2:0]             m_ack;
   wire  [`WB_DATA_W-1:0]  m_dat_r [3];

   wb_data_t   ref_mem [`SRAM_WORDS];
   logic [31:0] lfsr = 32'h8a14_ce3f;
   int          ack_order [$];
   logic [2:0]  prev_ack;
   int          cycles;

   wb_shared_sram i_wb_shared_sram (
      .clk (clk), .rst (rst),
      .m0_adr (m_adr[0]), .m0_dat_w (m_dat_w[0]), .m0_sel (m_sel[0]), .m0_we (m_we[0]),
      .m0_stb (m_stb[0]), .m0_cyc (m_cyc[0]), .m0_ack (m_ack[0]), .m0_dat_r (m_dat_r[0]),
      .m1_adr (m_adr[1]), .m1_dat_w (m_dat_w[1]), .m1_sel (m_sel[1]), .m1_we (m_we[1]),
      .m1_stb (m_stb[1]), .m1_cyc (m_cyc[1]), .m1_ack (m_ack[1]), .m1_dat_r (m_dat_r[1]),
      .m2_adr (m_adr[2]), .m2_dat_w (m_dat_w[2]), .m2_sel (m_sel[2]), .m2_we (m_we[2]),
      .m2_stb (m_stb[2]), .m2_cyc (m_cyc[2]), .m2_ack (m_ack[2]), .m2_dat_r (m_dat_r[2])
   );

   always #50 clk = ~clk;

   task automatic abort_run();
      $display("TB FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check(string name, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   // galois lfsr with taps 32 22 2 1
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic wb_addr_t rand_addr();
      return wb_addr_t'(take_bits(WORD_AW)) << 2;
   endfunction

   // byte lane rule of the memory
   function automatic void ref_write(wb_addr_t adr, wb_data_t dat, wb_sel_t sel);
      for (int i = 0; i < `WB_SEL_W; i++) begin
         if (sel[i]) begin
            ref_mem[adr >> 2][i*8 +: 8] = dat[i*8 +: 8];
         end
      end
   endfunction

   // one classic transfer where keep leaves cyc high for a locked sequence
   task automatic bus_cycle(int m, logic we, wb_addr_t adr, wb_data_t dat_w, wb_sel_t sel,
                            bit keep, output wb_data_t dat_r, output int lat);
      @(negedge clk);
      m_adr[m]   = adr;
      m_dat_w[m] = dat_w;
      m_sel[m]   = sel;
      m_we[m]    = we;
      m_stb[m]   = 1'b1;
      m_cyc[m]   = 1'b1;
      lat = 0;
      do begin
         @(negedge clk);
         lat++;
      end while (m_ack[m] !== 1'b1);
      dat_r    = m_dat_r[m];
      m_stb[m] = 1'b0;
      m_cyc[m] = keep;
   endtask

   task automatic wb_write(int m, wb_addr_t adr, wb_data_t dat, wb_sel_t sel, bit keep,
                           output int lat);
      wb_data_t unused;
      bus_cycle(m, 1'b1, adr, dat, sel, keep, unused, lat);
   endtask

   task automatic wb_read(int m, wb_addr_t adr, bit keep, output wb_data_t dat,
                          output int lat);
      bus_cycle(m, 1'b0, adr, '0, '1, keep, dat, lat);
   endtask

   // wait one quiet cycle so the log starts clean
   task automatic clear_ack_log();
      @(negedge clk);
      ack_order.delete();
   endtask

   task automatic check_order(string name, input int exp [$]);
      // the ack log samples on the same edge that ends the last transfer
      @(posedge clk);
      check(name, exp.size(), ack_order.size());
      foreach (exp[k]) begin
         check(name, exp[k], ack_order[k]);
      end
   endtask

   task automatic test_round_robin();
      wb_addr_t a [3];
      wb_data_t d [3];
      wb_data_t r [3];
      int       lat [3];
      int       exp_order [$];
      for (int i = 0; i < 3; i++) begin
         a[i] = wb_addr_t'('h300 + i * 4);
         d[i] = take_bits(32);
      end
      clear_ack_log();
      fork
         wb_write(0, a[0], d[0], '1, 0, lat[0]);
         wb_write(1, a[1], d[1], '1, 0, lat[1]);
         wb_write(2, a[2], d[2], '1, 0, lat[2]);
      join
      exp_order = {0, 1, 2};
      check_order("round robin after reset", exp_order);
      for (int i = 0; i < 3; i++) begin
         ref_write(a[i], d[i], '1);
      end
      // master 1 becomes the last owner
      wb_read(1, a[1], 0, r[1], lat[1]);
      check("round robin single read", ref_mem[a[1] >> 2], r[1]);
      clear_ack_log();
      fork
         wb_read(0, a[0], 0, r[0], lat[0]);
         wb_read(1, a[1], 0, r[1], lat[1]);
         wb_read(2, a[2], 0, r[2], lat[2]);
      join
      exp_order = {2, 0, 1};
      check_order("round robin after master 1", exp_order);
      for (int i = 0; i < 3; i++) begin
         check("round robin read data", ref_mem[a[i] >> 2], r[i]);
      end
   endtask

   task automatic test_single_master();
      wb_addr_t a [16];
      wb_data_t d;
      int       lat;
      for (int i = 0; i < 16; i++) begin
         a[i] = rand_addr();
         d    = take_bits(32);
         wb_write(0, a[i], d, '1, 0, lat);
         ref_write(a[i], d, '1);
         check("single master write latency", 2, lat);
      end
      for (int i = 0; i < 16; i++) begin
         wb_read(0, a[i], 0, d, lat);
         check("single master read latency", 2, lat);
         check("single master read data", ref_mem[a[i] >> 2], d);
      end
   endtask

   task automatic test_byte_lanes();
      logic [27:0] sel_seq;
      wb_addr_t    a;
      wb_data_t    d;
      wb_sel_t     sel;
      int          lat;
      // single lanes first, then mixed
      sel_seq = 28'h6a5_8421;
      a = rand_addr();
      d = take_bits(32);
      wb_write(1, a, d, '1, 0, lat);
      ref_write(a, d, '1);
      for (int i = 0; i < 7; i++) begin
         sel = sel_seq[i*4 +: 4];
         d   = take_bits(32);
         wb_write(1, a, d, sel, 0, lat);
         ref_write(a, d, sel);
         wb_read(1, a, 0, d, lat);
         check("byte lanes", ref_mem[a >> 2], d);
      end
   endtask

   task automatic test_locked_cycle();
      wb_addr_t a [4];
      wb_data_t d;
      wb_data_t r;
      int       lat;
      int       lat0;
      int       exp_order [$];
      for (int i = 0; i < 4; i++) begin
         a[i] = wb_addr_t'('h200 + i * 4);
      end
      clear_ack_log();
      fork
         begin
            for (int i = 0; i < 4; i++) begin
               d = take_bits(32);
               wb_write(2, a[i], d, '1, i < 3, lat);
               ref_write(a[i], d, '1);
            end
         end
         begin
            @(negedge clk);
            wb_read(0, a[3], 0, r, lat0);
         end
      join
      exp_order = {2, 2, 2, 2, 0};
      check_order("locked cycle order", exp_order);
      check("locked cycle read data", ref_mem[a[3] >> 2], r);
   endtask

   task automatic test_shared_memory();
      wb_addr_t a [4];
      wb_data_t d;
      int       lat;
      for (int i = 0; i < 4; i++) begin
         a[i] = rand_addr();
         d    = take_bits(32);
         wb_write(0, a[i], d, '1, 0, lat);
         ref_write(a[i], d, '1);
      end
      for (int i = 0; i < 4; i++) begin
         wb_read(2, a[i], 0, d, lat);
         check("shared memory", ref_mem[a[i] >> 2], d);
      end
   endtask

   // ack log, one cycle pulses and response isolation
   always @(negedge clk) begin
      if (rst) begin
         prev_ack <= '0;
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (m_ack[i]) begin
               ack_order.push_back(i);
               if (prev_ack[i]) begin
                  $display("ack of master %0d stayed high for more than one cycle", i);
                  abort_run();
               end
               for (int j = 0; j < 3; j++) begin
                  if (j != i) begin
                     check("response isolation ack", 0, m_ack[j]);
                     check("response isolation dat_r", 0, m_dat_r[j]);
                  end
               end
            end
         end
         prev_ack <= m_ack;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   initial begin
      clk    = 1'b0;
      rst    = 1'b1;
      cycles = 0;
      for (int i = 0; i < 3; i++) begin
         m_adr[i]   = '0;
         m_dat_w[i] = '0;
         m_sel[i]   = '0;
         m_we[i]    = 1'b0;
         m_stb[i]   = 1'b0;
         m_cyc[i]   = 1'b0;
      end
      repeat (8) @(negedge clk);
      rst = 1'b0;
      test_round_robin();
      test_single_master();
      test_byte_lanes();
      test_locked_cycle();
      test_shared_memory();
      @(negedge clk);
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: sim.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/wishbone_if.sv
hdl/wb_arbiter.sv
hdl/wb_mux3to1.sv
hdl/wb_sram.sv
hdl/wb_shared_sram.sv
testbench/tb_wb_shared_sram.sv

// File: Bender.yml
package:
  name: wb_shared_sram

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wb_pkg.sv
      - hdl/wishbone_if.sv
      - hdl/wb_arbiter.sv
      - hdl/wb_mux3to1.sv
      - hdl/wb_sram.sv
      - hdl/wb_shared_sram.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_wb_shared_sram.sv
